// ==== Makefile ====
# Verilator build and run for the divide and square-root testbench

TOP := tb_divsqrt_multi
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f vlog.f -Mdir obj_dir -o V$(TOP)

# The log must hold the pass line, otherwise the target fails
run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== logic/divsqrt_ctrl.sv ====
// Control FSM: starts the iterative unit, tracks the tag and holds results under back-pressure
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl
  import divsqrt_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         flush_i,
  // Tail of the input pipe
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  divsqrt_req_t req_i,
  // Towards the iterative unit
  output logic         start_div_o,
  output logic         start_sqrt_o,
  output data_t        operand_a_o,
  output data_t        operand_b_o,
  // Unit status after the delay line
  input  unit_out_t    unit_i,
  // Head of the output pipe
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,
  output divsqrt_rsp_t rsp_o,
  // Operation in flight
  output logic         busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        can_start;     // request waiting and unit free
  logic        req_ready;     // high only in a start cycle
  logic        out_valid;
  logic        hold_result;   // park the live result
  logic        data_is_held;
  logic        unit_busy;
  tag_t        tag_q;
  data_t       held_result_q;
  logic        held_div_zero_q;

  // Unit ready is seen through the delay line, so it lags after a flush
  assign can_start = req_valid_i & unit_i.ready;

  // --------------------
  // FSM
  // --------------------
  // Done arrives DATA_W or DATA_W/2 unit cycles after start, plus the delay line
  always_comb begin
    req_ready    = 1'b0;
    out_valid    = 1'b0;
    hold_result  = 1'b0;
    data_is_held = 1'b0;
    unit_busy    = 1'b0;
    state_d      = state_q;

    unique case (state_q)
      // Waiting for work
      IDLE: begin
        if (can_start) begin
          req_ready = 1'b1;
          state_d   = BUSY;
        end
      end
      // Unit running
      BUSY: begin
        unit_busy = 1'b1;
        if (unit_i.done) begin
          out_valid = 1'b1;
          if (rsp_ready_i) begin
            state_d = IDLE;
            // Back to back, next op starts on handover
            if (can_start) begin
              req_ready = 1'b1;
              state_d   = BUSY;
            end
          end else begin
            hold_result = 1'b1;
            state_d     = HOLD;
          end
        end
      end
      // Result parked until downstream takes it
      HOLD: begin
        unit_busy    = 1'b1;
        data_is_held = 1'b1;
        out_valid    = 1'b1;
        if (rsp_ready_i) begin
          state_d = IDLE;
          if (can_start) begin
            req_ready = 1'b1;
            state_d   = BUSY;
          end
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush cancels everything in flight
    if (flush_i) begin
      req_ready = 1'b0;
      out_valid = 1'b0;
      unit_busy = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Unit start
  // --------------------
  assign req_ready_o  = req_ready;
  assign start_div_o  = req_ready & (req_i.op == OP_DIV);
  assign start_sqrt_o = req_ready & (req_i.op == OP_SQRT);
  assign operand_a_o  = req_i.operand_a;
  assign operand_b_o  = req_i.operand_b;

  // Tag captured at start, travels beside the unit
  always_ff @(posedge clk_i) begin
    if (req_ready) begin
      tag_q <= req_i.tag;
    end
  end

  // Hold register
  always_ff @(posedge clk_i) begin
    if (hold_result) begin
      held_result_q   <= unit_i.result;
      held_div_zero_q <= unit_i.div_zero;
    end
  end

  // --------------------
  // Output select
  // --------------------
  // Held data wins over the live unit output
  always_comb begin
    rsp_o.result   = data_is_held ? held_result_q : unit_i.result;
    rsp_o.div_zero = data_is_held ? held_div_zero_q : unit_i.div_zero;
    rsp_o.tag      = tag_q;
  end

  assign rsp_valid_o = out_valid;
  assign busy_o      = unit_busy;

endmodule

`default_nettype wire

// ==== logic/divsqrt_iter.sv ====
// Iterative unit: restoring divider and digit-by-digit square root, one bit per cycle
`timescale 1ns/1ps
`default_nettype none

module divsqrt_iter
  import divsqrt_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  // Cancels the running operation
  input  logic      kill_i,
  // One-cycle start pulses with their operands
  input  logic      start_div_i,
  input  logic      start_sqrt_i,
  input  data_t     operand_a_i,
  input  data_t     operand_b_i,
  // Result, flag, ready and done pulse
  output unit_out_t unit_o
);

  // Index of the final step per operation
  localparam iter_cnt_t LAST_DIV  = iter_cnt_t'(DATA_W - 1);
  localparam iter_cnt_t LAST_SQRT = iter_cnt_t'(DATA_W / 2 - 1);

  typedef enum logic [1:0] {IDLE, RUN, DONE} iter_state_e;

  iter_state_e state_q;
  iter_state_e state_d;
  iter_cnt_t   cnt_q;
  logic        sqrt_q;
  logic        div_zero_q;
  logic        unit_ready;
  logic        start;
  logic        last_step;

  // Datapath shared by both operations
  logic [DATA_W:0] rem_q;      // partial remainder
  data_t           shift_q;    // operand a, bits consumed from the top
  data_t           res_q;      // quotient or root bits
  data_t           divisor_q;

  // One step of the recurrence
  logic [DATA_W:0]   cur_rem;
  logic [DATA_W:0]   rem_sh;
  logic [DATA_W:0]   trial;
  logic [DATA_W:0]   rem_next;
  logic [DATA_W+1:0] diff;
  data_t             cur_a;
  data_t             cur_b;
  data_t             cur_res;
  data_t             shift_next;
  data_t             res_next;
  logic              cur_sqrt;
  logic              fits;

  // Accepts work whenever no operation is running
  assign unit_ready = (state_q != RUN);
  assign start      = (start_div_i | start_sqrt_i) & unit_ready & ~kill_i;
  assign last_step  = (cnt_q == (sqrt_q ? LAST_SQRT : LAST_DIV));

  // --------------------
  // Step datapath
  // --------------------
  always_comb begin
    // First step runs in the start cycle, straight from the operands
    cur_rem  = start ? '0 : rem_q;
    cur_a    = start ? operand_a_i : shift_q;
    cur_b    = start ? operand_b_i : divisor_q;
    cur_res  = start ? '0 : res_q;
    cur_sqrt = start ? start_sqrt_i : sqrt_q;

    if (cur_sqrt) begin
      // Bring down two bits, try 4 * root + 1
      rem_sh     = {cur_rem[DATA_W-2:0], cur_a[DATA_W-1 -: 2]};
      trial      = {cur_res[DATA_W-2:0], 2'b01};
      shift_next = cur_a << 2;
    end else begin
      // Bring down one bit, try the divisor
      rem_sh     = {cur_rem[DATA_W-1:0], cur_a[DATA_W-1]};
      trial      = {1'b0, cur_b};
      shift_next = cur_a << 1;
    end

    // No borrow means the trial fits, keep the difference
    diff     = {1'b0, rem_sh} - {1'b0, trial};
    fits     = ~diff[DATA_W+1];
    rem_next = fits ? diff[DATA_W:0] : rem_sh;
    res_next = {cur_res[DATA_W-2:0], fits};
  end

  // --------------------
  // Control FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (last_step) begin
          state_d = DONE;
        end
      end
      // Done lasts one cycle, a new start may follow at once
      DONE: begin
        state_d = start ? RUN : IDLE;
      end
      default: state_d = IDLE;
    endcase
    // Kill wins over everything
    if (kill_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      sqrt_q     <= 1'b0;
      div_zero_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start) begin
        // Step 0 is done at this edge
        cnt_q      <= iter_cnt_t'(1);
        sqrt_q     <= start_sqrt_i;
        div_zero_q <= ~start_sqrt_i & (operand_b_i == '0);
      end else if (state_q == RUN) begin
        cnt_q <= cnt_q + iter_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start || (state_q == RUN)) begin
      rem_q   <= rem_next;
      shift_q <= shift_next;
      res_q   <= res_next;
    end
    if (start) begin
      divisor_q <= operand_b_i;
    end
  end

  // Quotient reads all ones on a zero divisor
  always_comb begin
    unit_o.result   = div_zero_q ? '1 : res_q;
    unit_o.div_zero = div_zero_q;
    unit_o.ready    = unit_ready;
    unit_o.done     = (state_q == DONE);
  end

endmodule

`default_nettype wire

// ==== logic/divsqrt_multi.sv ====
// Multi-cycle unsigned divide and square-root unit with elastic input and output pipes
`timescale 1ns/1ps
`default_nettype none

module divsqrt_multi
  import divsqrt_pkg::*;
#(
  // Register stages before the control FSM
  parameter int unsigned NUM_INP_REGS        = 1,
  // Register stages after the control FSM
  parameter int unsigned NUM_OUT_REGS        = 1,
  // Retiming stages on the unit outputs
  parameter int unsigned OUTPUT_DELAY_STAGES = 4
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         flush_i,
  // Request handshake
  input  logic         in_valid_i,
  output logic         in_ready_o,
  input  divsqrt_req_t req_i,
  // Response handshake
  output logic         out_valid_o,
  input  logic         out_ready_i,
  output divsqrt_rsp_t rsp_o,
  // Anything in flight
  output logic         busy_o
);

  // Input pipe to control
  logic         inp_valid;
  logic         inp_ready;
  divsqrt_req_t inp_req;
  logic         inp_busy;

  // Control to unit
  logic         start_div;
  logic         start_sqrt;
  data_t        operand_a;
  data_t        operand_b;
  logic         ctrl_busy;

  // Unit outputs, before and after retiming
  unit_out_t    unit_raw;
  unit_out_t    unit_dly;

  // Control to output pipe
  logic         ctrl_rsp_valid;
  logic         ctrl_rsp_ready;
  divsqrt_rsp_t ctrl_rsp;
  logic         out_busy;

  // --------------------
  // Input side
  // --------------------
  elastic_pipe #(
    .DEPTH     ( NUM_INP_REGS  ),
    .payload_t ( divsqrt_req_t )
  ) u_inp_pipe (
    .clk_i       ( clk_i      ),
    .rst_i       ( rst_i      ),
    .flush_i     ( flush_i    ),
    .in_valid_i  ( in_valid_i ),
    .in_ready_o  ( in_ready_o ),
    .in_data_i   ( req_i      ),
    .out_valid_o ( inp_valid  ),
    .out_ready_i ( inp_ready  ),
    .out_data_o  ( inp_req    ),
    .busy_o      ( inp_busy   )
  );

  // --------------------
  // Control and unit
  // --------------------
  divsqrt_ctrl u_ctrl (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .flush_i      ( flush_i        ),
    .req_valid_i  ( inp_valid      ),
    .req_ready_o  ( inp_ready      ),
    .req_i        ( inp_req        ),
    .start_div_o  ( start_div      ),
    .start_sqrt_o ( start_sqrt     ),
    .operand_a_o  ( operand_a      ),
    .operand_b_o  ( operand_b      ),
    .unit_i       ( unit_dly       ),
    .rsp_valid_o  ( ctrl_rsp_valid ),
    .rsp_ready_i  ( ctrl_rsp_ready ),
    .rsp_o        ( ctrl_rsp       ),
    .busy_o       ( ctrl_busy      )
  );

  // Flush doubles as the unit's kill
  divsqrt_iter u_iter (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .kill_i       ( flush_i    ),
    .start_div_i  ( start_div  ),
    .start_sqrt_i ( start_sqrt ),
    .operand_a_i  ( operand_a  ),
    .operand_b_i  ( operand_b  ),
    .unit_o       ( unit_raw   )
  );

  unit_delay_line #(
    .DELAY_STAGES ( OUTPUT_DELAY_STAGES )
  ) u_delay (
    .clk_i   ( clk_i    ),
    .rst_i   ( rst_i    ),
    .flush_i ( flush_i  ),
    .unit_i  ( unit_raw ),
    .unit_o  ( unit_dly )
  );

  // --------------------
  // Output side
  // --------------------
  elastic_pipe #(
    .DEPTH     ( NUM_OUT_REGS  ),
    .payload_t ( divsqrt_rsp_t )
  ) u_out_pipe (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .flush_i     ( flush_i        ),
    .in_valid_i  ( ctrl_rsp_valid ),
    .in_ready_o  ( ctrl_rsp_ready ),
    .in_data_i   ( ctrl_rsp       ),
    .out_valid_o ( out_valid_o    ),
    .out_ready_i ( out_ready_i    ),
    .out_data_o  ( rsp_o          ),
    .busy_o      ( out_busy       )
  );

  assign busy_o = inp_busy | ctrl_busy | out_busy;

endmodule

`default_nettype wire

// ==== logic/divsqrt_pkg.sv ====
// Divide and square-root unit: shared widths, operation encoding and payload records
`default_nettype none

package divsqrt_pkg;

  // --------------------
  // Widths
  // --------------------
  // Operand and result width
  localparam int unsigned DATA_W = 32;
  // Width of the caller's identifier
  localparam int unsigned TAG_W  = 4;

  // One operand or result word
  typedef logic [DATA_W-1:0] data_t;
  // Caller's identifier, travels with the operation
  typedef logic [TAG_W-1:0] tag_t;
  // Step counter, wide enough for DATA_W steps
  typedef logic [$clog2(DATA_W+1)-1:0] iter_cnt_t;

  // --------------------
  // Operations
  // --------------------
  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divsqrt_op_e;

  // --------------------
  // Payload records
  // --------------------
  // Request, input pipe payload (69 bits)
  typedef struct packed {
    data_t       operand_a;
    data_t       operand_b;
    divsqrt_op_e op;
    tag_t        tag;
  } divsqrt_req_t;

  // Response, output pipe payload (37 bits)
  typedef struct packed {
    data_t result;
    logic  div_zero;
    tag_t  tag;
  } divsqrt_rsp_t;

  // Unit status and result, through the delay line (35 bits)
  typedef struct packed {
    data_t result;
    logic  div_zero;
    logic  ready;
    logic  done;
  } unit_out_t;

endpackage

`default_nettype wire

// ==== logic/elastic_pipe.sv ====
// Elastic register chain with valid/ready handshake, flush and occupancy flag
`timescale 1ns/1ps
`default_nettype none

module elastic_pipe #(
  // Register stages, zero makes the chain plain wires
  parameter int unsigned DEPTH     = 1,
  // Record carried by each stage
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // Downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o,
  // Some stage holds a valid item
  output logic     busy_o
);

  // Index i is the signal after i register stages
  logic     [0:DEPTH] valid_q;
  logic     [0:DEPTH] ready;
  payload_t [0:DEPTH] data_q;

  // Chain head is the upstream request
  assign valid_q[0] = in_valid_i;
  assign data_q[0]  = in_data_i;
  assign in_ready_o = ready[0];

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    logic load;

    // Advance when the next stage moves on or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Payload moves only with a valid item
    assign load     = ready[i] & valid_q[i];

    // Valid bit, cleared by reset and flush
    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Chain tail faces downstream
  assign ready[DEPTH] = out_ready_i;
  assign out_valid_o  = valid_q[DEPTH];
  assign out_data_o   = data_q[DEPTH];

  // Occupancy over the register stages only
  always_comb begin
    busy_o = 1'b0;
    for (int i = 1; i <= DEPTH; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/unit_delay_line.sv ====
// Fixed retiming of the iterative unit's outputs, done pulses dropped on flush
`timescale 1ns/1ps
`default_nettype none

module unit_delay_line
  import divsqrt_pkg::*;
#(
  // Register stages between unit and control
  parameter int unsigned DELAY_STAGES = 4
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      flush_i,
  // Straight from the unit
  input  unit_out_t unit_i,
  // Towards the control FSM
  output unit_out_t unit_o
);

  // Index i is the unit output after i cycles
  unit_out_t [0:DELAY_STAGES] stage_q;

  assign stage_q[0] = unit_i;

  for (genvar i = 0; i < DELAY_STAGES; i++) begin : gen_stage
    always_ff @(posedge clk_i) begin
      // Shifts every cycle, no enable
      stage_q[i+1] <= stage_q[i];
      // A cancelled operation must not report completion
      if (rst_i || flush_i) begin
        stage_q[i+1].done <= 1'b0;
      end
      // Idle unit is ready
      if (rst_i) begin
        stage_q[i+1].ready <= 1'b1;
      end
    end
  end

  assign unit_o = stage_q[DELAY_STAGES];

endmodule

`default_nettype wire

// ==== verification/divsqrt_cases.txt ====
# op a b tag result div_zero, all in hex
# op 0 divides a by b, op 1 takes the square root of a and ignores b
0 00000064 0000000a 1 0000000a 0
0 ffffffff 00000001 2 ffffffff 0
1 00000010 00000000 3 00000004 0
0 ffffffff 00000002 4 7fffffff 0
0 00000007 00000009 5 00000000 0
0 12345678 00000000 6 ffffffff 1
1 00000000 00000000 7 00000000 0
1 00000001 00000000 8 00000001 0
1 00000011 00000000 9 00000004 0
1 ffffffff 00000000 a 0000ffff 0
1 fffe0001 00000000 b 0000ffff 0
1 fffe0000 00000000 c 0000fffe 0
0 80000000 00000003 d 2aaaaaaa 0
0 deadbeef 00010000 e 0000dead 0
0 0000ffff 0000ffff f 00000001 0
0 00000000 00000000 0 ffffffff 1
1 00002710 00000000 1 00000064 0
1 000f4240 00000000 2 000003e8 0
1 000f423f 00000000 3 000003e7 0
0 000f4240 000003e8 4 000003e8 0
0 fffffffe ffffffff 5 00000000 0
1 40000000 00000000 6 00008000 0
1 3fffffff 00000000 7 00007fff 0
1 00000019 12345678 8 00000005 0

// ==== verification/tb_divsqrt_multi.sv ====
// Testbench for the divide and square-root unit with file-driven cases, back-pressure and flush
`timescale 1ns/1ps
`default_nettype none

module tb_divsqrt_multi
  import divsqrt_pkg::*;
();

  localparam int    MAX_CASES      = 64;
  localparam int    TIMEOUT_CYCLES = 400;
  localparam int    WATCH_CYCLES   = 100;
  localparam string CASE_FILE      = "verification/divsqrt_cases.txt";

  logic         clk;
  logic         rst;
  logic         flush;
  logic         in_valid;
  logic         in_ready;
  divsqrt_req_t req;
  logic         out_valid;
  logic         out_ready;
  divsqrt_rsp_t rsp;
  logic         busy;
  logic         random_bp;

  // Cases from the file
  divsqrt_req_t case_req     [MAX_CASES];
  data_t        exp_result   [MAX_CASES];
  logic         exp_div_zero [MAX_CASES];
  int           num_cases;

  int mismatch_errors;
  int timeout_errors;
  int flow_errors;

  divsqrt_multi #(
    .NUM_INP_REGS        ( 1 ),
    .NUM_OUT_REGS        ( 1 ),
    .OUTPUT_DELAY_STAGES ( 4 )
  ) divsqrt_multi_i (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .flush_i     ( flush     ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .req_i       ( req       ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .rsp_o       ( rsp       ),
    .busy_o      ( busy      )
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    begin
      assert (got === exp) else begin
        $display("MISMATCH %s got=0x%h expected=0x%h", name, got, exp);
        mismatch_errors++;
      end
    end
  endtask

  // Lines starting with # are comments
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_tag;
    logic [31:0] f_res;
    logic [31:0] f_dz;
    begin
      num_cases = 0;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
        $display("ERROR: cannot open the case file %s", CASE_FILE);
        flow_errors++;
      end else begin
        while (!$feof(fd) && num_cases < MAX_CASES) begin
          line = "";
          void'($fgets(line, fd));
          if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_a, f_b, f_tag, f_res, f_dz);
            if (n == 6) begin
              case_req[num_cases].operand_a = f_a;
              case_req[num_cases].operand_b = f_b;
              case_req[num_cases].op        = divsqrt_op_e'(f_op[0]);
              case_req[num_cases].tag       = f_tag[TAG_W-1:0];
              exp_result[num_cases]         = f_res;
              exp_div_zero[num_cases]       = f_dz[0];
              num_cases++;
            end else begin
              $display("ERROR: case file line has %0d fields instead of 6", n);
              flow_errors++;
            end
          end
        end
        $fclose(fd);
      end
    end
  endtask

  // Offer one request and hold it until the DUT takes it
  task automatic send_request(input int idx);
    int cycles;
    begin
      @(posedge clk);
      #2;
      in_valid = 1'b1;
      req      = case_req[idx];
      cycles   = 0;
      @(negedge clk);
      while (!in_ready && cycles < TIMEOUT_CYCLES) begin
        cycles++;
        @(negedge clk);
      end
      if (!in_ready) begin
        $display("ERROR: request %0d not accepted within %0d cycles", idx, TIMEOUT_CYCLES);
        timeout_errors++;
      end
      // Transfer happens at this edge
      @(posedge clk);
      #2;
      in_valid = 1'b0;
    end
  endtask

  // Wait for the next transfer on the response side and compare it
  task automatic expect_response(input int idx);
    int cycles;
    begin
      cycles = 0;
      @(negedge clk);
      while (!(out_valid && out_ready) && cycles < TIMEOUT_CYCLES) begin
        cycles++;
        @(negedge clk);
      end
      if (out_valid && out_ready) begin
        check_value("rsp_o.tag", 32'(rsp.tag), 32'(case_req[idx].tag));
        check_value("rsp_o.result", rsp.result, exp_result[idx]);
        check_value("rsp_o.div_zero", 32'(rsp.div_zero), 32'(exp_div_zero[idx]));
      end else begin
        $display("ERROR: no response for case %0d within %0d cycles", idx, TIMEOUT_CYCLES);
        timeout_errors++;
      end
    end
  endtask

  // Two requests go in and are then cancelled
  task automatic run_flush_test();
    int seen;
    begin
      send_request(0);
      send_request(1);
      @(negedge clk);
      check_value("busy_o", 32'(busy), 32'h1);
      @(posedge clk);
      #2;
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
      @(negedge clk);
      check_value("busy_o", 32'(busy), 32'h0);
      // Cancelled work never comes out
      seen = 0;
      for (int c = 0; c < WATCH_CYCLES; c++) begin
        @(negedge clk);
        if (out_valid) begin
          seen++;
        end
      end
      assert (seen == 0) else begin
        $display("ERROR: %0d responses appeared for flushed requests", seen);
        flow_errors++;
      end
      // Next case runs normally
      fork
        send_request(2);
        expect_response(2);
      join
    end
  endtask

  // --------------------
  // Back-pressure
  // --------------------
  // Low in about a third of the cycles when random
  initial begin
    void'($urandom(36));
    forever begin
      @(posedge clk);
      #2;
      if (random_bp) begin
        out_ready = ($urandom % 3) != 0;
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // Stalled payload stays put unless a flush clears it
  initial begin
    logic         stalled;
    divsqrt_rsp_t stalled_rsp;
    stalled     = 1'b0;
    stalled_rsp = '0;
    forever begin
      @(negedge clk);
      if (stalled) begin
        assert (out_valid) else begin
          $display("ERROR: out_valid_o dropped while out_ready_i was low");
          flow_errors++;
        end
        check_value("rsp_o.result", rsp.result, stalled_rsp.result);
        check_value("rsp_o.div_zero", 32'(rsp.div_zero), 32'(stalled_rsp.div_zero));
        check_value("rsp_o.tag", 32'(rsp.tag), 32'(stalled_rsp.tag));
      end
      stalled     = out_valid && !out_ready && !flush && !rst;
      stalled_rsp = rsp;
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int total;
    rst             = 1'b1;
    flush           = 1'b0;
    in_valid        = 1'b0;
    req             = '0;
    out_ready       = 1'b1;
    random_bp       = 1'b0;
    mismatch_errors = 0;
    timeout_errors  = 0;
    flow_errors     = 0;
    load_cases();

    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    // Idle after reset
    @(negedge clk);
    check_value("out_valid_o", 32'(out_valid), 32'h0);
    check_value("busy_o", 32'(busy), 32'h0);
    check_value("in_ready_o", 32'(in_ready), 32'h1);

    // All cases in order under random back-pressure
    random_bp = 1'b1;
    fork
      begin
        for (int k = 0; k < num_cases; k++) begin
          send_request(k);
        end
      end
      begin
        for (int k = 0; k < num_cases; k++) begin
          expect_response(k);
        end
      end
    join
    random_bp = 1'b0;

    if (num_cases >= 3) begin
      run_flush_test();
    end else begin
      $display("ERROR: the flush test needs at least 3 cases, found %0d", num_cases);
      flow_errors++;
    end

    total = mismatch_errors + timeout_errors + flow_errors;
    $display("Errors: mismatch %0d, timeout %0d, other %0d",
             mismatch_errors, timeout_errors, flow_errors);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/divsqrt_pkg.sv
logic/elastic_pipe.sv
logic/divsqrt_iter.sv
logic/unit_delay_line.sv
logic/divsqrt_ctrl.sv
logic/divsqrt_multi.sv
verification/tb_divsqrt_multi.sv
